// File: cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define CPU_WORD_W   16
`define CPU_ADDR_W   8
`define CPU_NREGS    8
// First instruction fetch address
`define CPU_RESET_PC 0

`endif

// File: cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

  typedef logic [`CPU_WORD_W-1:0] word_t;
  typedef logic [`CPU_ADDR_W-1:0] addr_t;
  typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;

  // Bit layout 15..13 opcode, 12..11 op, 10..8 rn, 7..5 rd, 4..3 shift, 2..0 rm
  typedef struct packed {
    logic [2:0] opcode;
    logic [1:0] op;
    reg_idx_t   rn;
    reg_idx_t   rd;
    logic [1:0] shift;
    reg_idx_t   rm;
  } instr_t;

  typedef struct packed {
    logic z;
    logic n;
    logic v;
  } flags_t;

  typedef enum logic [1:0] {
    WB_C     = 2'b00,
    WB_IMM8  = 2'b10,
    WB_MDATA = 2'b11
  } wb_sel_t;

  typedef enum logic [1:0] {
    RF_RM = 2'b00,
    RF_RD = 2'b01,
    RF_RN = 2'b10
  } reg_field_t;

  typedef enum logic [4:0] {
    S_RESET, S_FETCH, S_DECODE, S_LOAD_A, S_LOAD_B, S_ALU, S_PASS_B, S_ADDR_CALC,
    S_STATUS, S_WRITE_CONST, S_WRITEBACK, S_DAR, S_MEM_READ, S_MEM_WRITE,
    S_WRITE_MDATA, S_NEXT, S_HALT
  } ctrl_state_t;

  localparam logic [2:0] OPC_MOV = 3'b110;
  localparam logic [2:0] OPC_ALU = 3'b101;
  localparam logic [2:0] OPC_LDR = 3'b011;
  localparam logic [2:0] OPC_STR = 3'b100;

  localparam logic [1:0] OP_MOV_IMM = 2'b10;
  localparam logic [1:0] OP_MOV_REG = 2'b00;
  localparam logic [1:0] OP_MEM     = 2'b00;
  localparam logic [1:0] OP_ADD     = 2'b00;
  localparam logic [1:0] OP_CMP     = 2'b01;
  localparam logic [1:0] OP_AND     = 2'b10;
  localparam logic [1:0] OP_MVN     = 2'b11;

endpackage

// File: dp_ctrl_if.sv
`timescale 1ns/1ps

interface dp_ctrl_if;
  import cpu_pkg::*;

  reg_field_t reg_field;
  wb_sel_t    wb_sel;
  logic       w_en;
  logic       en_a;
  logic       en_b;
  logic       en_c;
  // A forced to zero, imm5 in place of B
  logic       sel_a;
  logic       sel_b;
  logic       en_status;

  modport control (
    output reg_field, wb_sel, w_en, en_a, en_b, en_c, sel_a, sel_b, en_status
  );

  modport datapath (
    input reg_field, wb_sel, w_en, en_a, en_b, en_c, sel_a, sel_b, en_status
  );

endinterface

// File: bus_ctrl_if.sv
`timescale 1ns/1ps

interface bus_ctrl_if;
  import cpu_pkg::*;

  // go is held until done pulses
  logic   go;
  logic   we;
  logic   use_data_addr;
  logic   load_pc;
  logic   load_addr;
  logic   done;
  instr_t ir;

  modport control (output go, we, use_data_addr, load_pc, load_addr, input done, ir);

  modport bus (input go, we, use_data_addr, load_pc, load_addr, output done, ir);

endinterface

// File: bus_master.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module bus_master (
  input  logic           clk,
  input  logic           rst_n,
  bus_ctrl_if.bus        bus,
  input  cpu_pkg::word_t addr_src,
  input  cpu_pkg::word_t store_data,
  output logic           mem_req,
  output logic           mem_we,
  output cpu_pkg::addr_t mem_addr,
  output cpu_pkg::word_t mem_wdata,
  input  logic           mem_ack,
  input  cpu_pkg::word_t mem_rdata,
  output cpu_pkg::word_t mdata
);
  import cpu_pkg::*;

  typedef enum logic [1:0] {B_IDLE, B_REQ, B_RELEASE, B_DONE} bus_state_t;

  bus_state_t state;
  addr_t      pc;
  addr_t      dar;

  assign bus.done = (state == B_DONE);

  // Four-phase handshake
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state   <= B_IDLE;
      mem_req <= 1'b0;
      mem_we  <= 1'b0;
    end else begin
      case (state)
        B_IDLE: begin
          if (bus.go) begin
            mem_req <= 1'b1;
            mem_we  <= bus.we;
            state   <= B_REQ;
          end
        end
        B_REQ: begin
          if (mem_ack) begin
            mem_req <= 1'b0;
            mem_we  <= 1'b0;
            state   <= B_RELEASE;
          end
        end
        // Wait for ack to return low
        B_RELEASE: begin
          if (!mem_ack) begin
            state <= B_DONE;
          end
        end
        default: state <= B_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == B_IDLE && bus.go) begin
      mem_addr  <= bus.use_data_addr ? dar : pc;
      mem_wdata <= store_data;
    end
    // Read data is valid while ack is high
    if (state == B_REQ && mem_ack && !mem_we) begin
      if (bus.use_data_addr) begin
        mdata <= mem_rdata;
      end else begin
        bus.ir <= instr_t'(mem_rdata);
      end
    end
    if (bus.load_addr) begin
      dar <= addr_src[`CPU_ADDR_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      pc <= addr_t'(`CPU_RESET_PC);
    end else if (bus.load_pc) begin
      pc <= pc + 1'b1;
    end
  end

endmodule

// File: control_fsm.sv
`timescale 1ns/1ps

module control_fsm (
  input  logic        clk,
  input  logic        rst_n,
  dp_ctrl_if.control  ctl,
  bus_ctrl_if.control bus,
  output logic        halted
);
  import cpu_pkg::*;

  ctrl_state_t state;
  ctrl_state_t next_state;
  instr_t      ir;
  logic        is_mov_imm;
  logic        is_mov_reg;
  logic        is_alu;
  logic        is_cmp;
  logic        is_mvn;
  logic        is_ldr;
  logic        is_str;

  assign ir         = bus.ir;
  assign is_mov_imm = (ir.opcode == OPC_MOV) && (ir.op == OP_MOV_IMM);
  assign is_mov_reg = (ir.opcode == OPC_MOV) && (ir.op == OP_MOV_REG);
  assign is_alu     = (ir.opcode == OPC_ALU);
  assign is_cmp     = is_alu && (ir.op == OP_CMP);
  assign is_mvn     = is_alu && (ir.op == OP_MVN);
  assign is_ldr     = (ir.opcode == OPC_LDR) && (ir.op == OP_MEM);
  assign is_str     = (ir.opcode == OPC_STR) && (ir.op == OP_MEM);

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state  <= S_RESET;
      halted <= 1'b0;
    end else begin
      state <= next_state;
      if (state == S_HALT) begin
        halted <= 1'b1;
      end
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      S_RESET:  next_state = S_FETCH;
      S_FETCH:  next_state = bus.done ? S_DECODE : S_FETCH;
      S_DECODE: begin
        if (is_mov_imm) begin
          next_state = S_WRITE_CONST;
        end else if (is_mov_reg || is_mvn) begin
          next_state = S_LOAD_B;
        end else if (is_alu || is_ldr || is_str) begin
          next_state = S_LOAD_A;
        end else begin
          // HALT and every unknown encoding
          next_state = S_HALT;
        end
      end
      S_LOAD_A: next_state = (is_ldr || is_str) ? S_ADDR_CALC : S_LOAD_B;
      S_LOAD_B: begin
        if (is_mov_reg) begin
          next_state = S_PASS_B;
        end else if (is_cmp) begin
          next_state = S_STATUS;
        end else begin
          next_state = S_ALU;
        end
      end
      S_ALU:         next_state = S_WRITEBACK;
      S_PASS_B:      next_state = S_WRITEBACK;
      S_ADDR_CALC:   next_state = S_DAR;
      S_DAR:         next_state = is_str ? S_MEM_WRITE : S_MEM_READ;
      S_MEM_READ:    next_state = bus.done ? S_WRITE_MDATA : S_MEM_READ;
      S_MEM_WRITE:   next_state = bus.done ? S_NEXT : S_MEM_WRITE;
      S_STATUS:      next_state = S_NEXT;
      S_WRITE_CONST: next_state = S_NEXT;
      S_WRITEBACK:   next_state = S_NEXT;
      S_WRITE_MDATA: next_state = S_NEXT;
      S_NEXT:        next_state = S_FETCH;
      S_HALT:        next_state = S_HALT;
      default:       next_state = S_RESET;
    endcase
  end

  always_comb begin
    ctl.reg_field     = RF_RM;
    ctl.wb_sel        = WB_C;
    ctl.w_en          = 1'b0;
    ctl.en_a          = 1'b0;
    ctl.en_b          = 1'b0;
    ctl.en_c          = 1'b0;
    ctl.sel_a         = 1'b0;
    ctl.sel_b         = 1'b0;
    ctl.en_status     = 1'b0;
    bus.go            = 1'b0;
    bus.we            = 1'b0;
    bus.use_data_addr = 1'b0;
    bus.load_pc       = 1'b0;
    bus.load_addr     = 1'b0;
    case (state)
      S_FETCH: bus.go = 1'b1;
      S_LOAD_A: begin
        ctl.reg_field = RF_RN;
        ctl.en_a      = 1'b1;
      end
      S_LOAD_B: begin
        ctl.reg_field = RF_RM;
        ctl.en_b      = 1'b1;
      end
      S_ALU: ctl.en_c = 1'b1;
      S_PASS_B: begin
        ctl.sel_a = 1'b1;
        ctl.en_c  = 1'b1;
      end
      // Base plus imm5
      S_ADDR_CALC: begin
        ctl.sel_b = 1'b1;
        ctl.en_c  = 1'b1;
      end
      S_STATUS: ctl.en_status = 1'b1;
      S_WRITE_CONST: begin
        ctl.reg_field = RF_RN;
        ctl.wb_sel    = WB_IMM8;
        ctl.w_en      = 1'b1;
      end
      S_WRITEBACK: begin
        ctl.reg_field = RF_RD;
        ctl.wb_sel    = WB_C;
        ctl.w_en      = 1'b1;
      end
      S_WRITE_MDATA: begin
        ctl.reg_field = RF_RD;
        ctl.wb_sel    = WB_MDATA;
        ctl.w_en      = 1'b1;
      end
      S_DAR: bus.load_addr = 1'b1;
      S_MEM_READ: begin
        bus.go            = 1'b1;
        bus.use_data_addr = 1'b1;
      end
      S_MEM_WRITE: begin
        bus.go            = 1'b1;
        bus.we            = 1'b1;
        bus.use_data_addr = 1'b1;
      end
      S_NEXT: bus.load_pc = 1'b1;
      default: ;
    endcase
  end

endmodule

// File: datapath.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module datapath (
  input  logic            clk,
  input  logic            rst_n,
  dp_ctrl_if.datapath     ctl,
  input  cpu_pkg::instr_t ir,
  input  cpu_pkg::word_t  mdata,
  output cpu_pkg::word_t  c_out,
  output cpu_pkg::word_t  rd_data,
  output cpu_pkg::flags_t flags
);
  import cpu_pkg::*;

  localparam int MSB = `CPU_WORD_W - 1;

  word_t      regs [`CPU_NREGS];
  reg_idx_t   rf_idx;
  word_t      rf_rdata;
  word_t      wb_data;
  word_t      sximm8;
  word_t      sximm5;
  word_t      a_q;
  word_t      b_q;
  word_t      c_q;
  word_t      alu_a;
  word_t      alu_b;
  word_t      alu_y;
  logic [1:0] alu_op;

  assign sximm8 = {{(`CPU_WORD_W-8){ir.rd[2]}}, ir.rd, ir.shift, ir.rm};
  assign sximm5 = {{(`CPU_WORD_W-5){ir.shift[1]}}, ir.shift, ir.rm};

  always_comb begin
    case (ctl.reg_field)
      RF_RN:   rf_idx = ir.rn;
      RF_RD:   rf_idx = ir.rd;
      default: rf_idx = ir.rm;
    endcase
  end

  always_comb begin
    case (ctl.wb_sel)
      WB_C:     wb_data = c_q;
      WB_IMM8:  wb_data = sximm8;
      WB_MDATA: wb_data = mdata;
      default:  wb_data = c_q;
    endcase
  end

  assign rf_rdata = regs[rf_idx];
  assign rd_data  = regs[ir.rd];

  always_ff @(posedge clk) begin
    if (ctl.w_en) begin
      regs[rf_idx] <= wb_data;
    end
    if (ctl.en_a) begin
      a_q <= rf_rdata;
    end
    if (ctl.en_b) begin
      b_q <= rf_rdata;
    end
    if (ctl.en_c) begin
      c_q <= alu_y;
    end
  end

  // Moves and memory addressing always add
  assign alu_op = (ir.opcode == OPC_ALU) ? ir.op : OP_ADD;
  assign alu_a  = ctl.sel_a ? '0 : a_q;
  assign alu_b  = ctl.sel_b ? sximm5 : b_q;

  always_comb begin
    case (alu_op)
      OP_ADD:  alu_y = alu_a + alu_b;
      OP_CMP:  alu_y = alu_a - alu_b;
      OP_AND:  alu_y = alu_a & alu_b;
      OP_MVN:  alu_y = ~alu_b;
      default: alu_y = '0;
    endcase
  end

  // Signed overflow of A minus B
  always_ff @(posedge clk) begin
    if (rst_n) begin
      flags <= '0;
    end else if (ctl.en_status) begin
      flags.z <= (alu_y == '0);
      flags.n <= alu_y[MSB];
      flags.v <= (alu_a[MSB] ^ alu_b[MSB]) & (alu_y[MSB] ^ alu_a[MSB]);
    end
  end

  assign c_out = c_q;

endmodule

// File: cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
  input  logic            clk,
  input  logic            rst_n,
  output logic            mem_req,
  output logic            mem_we,
  output cpu_pkg::addr_t  mem_addr,
  output cpu_pkg::word_t  mem_wdata,
  input  logic            mem_ack,
  input  cpu_pkg::word_t  mem_rdata,
  output logic            halted,
  output cpu_pkg::flags_t flags
);
  import cpu_pkg::*;

  word_t c_out;
  word_t rd_data;
  word_t mdata;

  dp_ctrl_if  dp_if ();
  bus_ctrl_if bus_if ();

  bus_master u_bus (
    .clk        (clk),
    .rst_n      (rst_n),
    .bus        (bus_if.bus),
    .addr_src   (c_out),
    .store_data (rd_data),
    .mem_req    (mem_req),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_ack    (mem_ack),
    .mem_rdata  (mem_rdata),
    .mdata      (mdata)
  );

  control_fsm u_ctrl (
    .clk    (clk),
    .rst_n  (rst_n),
    .ctl    (dp_if.control),
    .bus    (bus_if.control),
    .halted (halted)
  );

  datapath u_dp (
    .clk     (clk),
    .rst_n   (rst_n),
    .ctl     (dp_if.datapath),
    .ir      (bus_if.ir),
    .mdata   (mdata),
    .c_out   (c_out),
    .rd_data (rd_data),
    .flags   (flags)
  );

endmodule

// File: cpu_tb_assertions.sv
`timescale 1ns/1ps

module cpu_tb_assertions (
  input logic           clk,
  input logic           rst_n,
  input logic           mem_req,
  input logic           mem_we,
  input cpu_pkg::addr_t mem_addr,
  input cpu_pkg::word_t mem_wdata,
  input logic           mem_ack
);

  // Request held until acknowledged
  assert property (@(posedge clk) disable iff (rst_n) mem_req && !mem_ack |=> mem_req)
    else $error("mem_req dropped before mem_ack");

  // Ack as seen at the edge where req was raised
  assert property (@(posedge clk) disable iff (rst_n) $rose(mem_req) |-> !$past(mem_ack))
    else $error("mem_req rose while mem_ack was still high");

  assert property (@(posedge clk) disable iff (rst_n)
    mem_req && $past(mem_req) |-> $stable(mem_addr) && $stable(mem_we) && $stable(mem_wdata))
    else $error("address, we or wdata changed while mem_req was high");

endmodule

bind cpu_top cpu_tb_assertions u_bus_check (
  .clk       (clk),
  .rst_n     (rst_n),
  .mem_req   (mem_req),
  .mem_we    (mem_we),
  .mem_addr  (mem_addr),
  .mem_wdata (mem_wdata),
  .mem_ack   (mem_ack)
);

// File: cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_tb;
  import cpu_pkg::*;

  localparam int RESET_CYCLES = 5;
  localparam int N_RANDOM     = 40;
  localparam int REQ_TIMEOUT  = 200;
  localparam int ACK_TIMEOUT  = 50;
  localparam int HALT_TIMEOUT = 20000;
  localparam int QUIET_CYCLES = 200;

  logic   clk = 1'b0;
  logic   rst_n;
  logic   mem_req;
  logic   mem_we;
  addr_t  mem_addr;
  word_t  mem_wdata;
  logic   mem_ack;
  word_t  mem_rdata;
  logic   halted;
  flags_t flags;

  word_t  prog [$];
  word_t  mem [256];
  word_t  model_mem [256];
  logic   exp_we [$];
  addr_t  exp_addr [$];
  word_t  exp_data [$];
  flags_t exp_flags;
  int     served;

  cpu_top dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .halted    (halted),
    .flags     (flags)
  );

  always #10 clk = ~clk;

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_addr(string name, addr_t expected, addr_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_word(string name, word_t expected, word_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_flags(string name, flags_t expected, flags_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("FAILED %s expected %b actual %b", name, expected, actual));
    end
  endtask

  task automatic check_bit(string name, logic expected, logic actual);
    if (actual !== expected) begin
      fail_run($sformatf("FAILED %s expected %b actual %b", name, expected, actual));
    end
  endtask

  function automatic word_t encode(logic [2:0] opc, logic [1:0] op, logic [2:0] rn,
                                   logic [7:0] low8);
    return {opc, op, rn, low8};
  endfunction

  task automatic add_access(logic we, addr_t addr, word_t data);
    exp_we.push_back(we);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  // R0 holds the data pointer and is never a destination after setup
  task automatic build_program();
    int unsigned kind;
    logic [2:0]  rd;
    logic [2:0]  rn;
    logic [2:0]  rm;
    int          i;
    prog.push_back(encode(3'b110, 2'b10, 3'd0, 8'hc0));
    for (i = 1; i < 8; i++) begin
      prog.push_back(encode(3'b110, 2'b10, 3'(i), 8'($urandom)));
    end
    for (i = 0; i < N_RANDOM; i++) begin
      kind = (i == N_RANDOM - 1) ? 3 : $urandom % 8;
      rd   = 3'(1 + $urandom % 7);
      rn   = 3'($urandom % 8);
      rm   = 3'($urandom % 8);
      case (kind)
        0: prog.push_back(encode(3'b110, 2'b10, rd, 8'($urandom)));
        1: prog.push_back(encode(3'b110, 2'b00, 3'd0, {rd, 2'b00, rm}));
        2: prog.push_back(encode(3'b101, 2'b00, rn, {rd, 2'b00, rm}));
        3: prog.push_back(encode(3'b101, 2'b01, rn, {3'd0, 2'b00, rm}));
        4: prog.push_back(encode(3'b101, 2'b10, rn, {rd, 2'b00, rm}));
        5: prog.push_back(encode(3'b101, 2'b11, 3'd0, {rd, 2'b00, rm}));
        6: prog.push_back(encode(3'b011, 2'b00, 3'd0, {rd, 5'($urandom)}));
        default: prog.push_back(encode(3'b100, 2'b00, 3'd0, {rm, 5'($urandom)}));
      endcase
    end
    // Register dump
    for (i = 0; i < 8; i++) begin
      prog.push_back(encode(3'b100, 2'b00, 3'd0, {3'(i), 5'(i)}));
    end
    prog.push_back(16'he000);
  endtask

  task automatic load_memory();
    int i;
    for (i = 0; i < 256; i++) begin
      if (i < prog.size()) begin
        mem[i] = prog[i];
      end else if (i >= 128) begin
        mem[i] = 16'($urandom);
      end else begin
        mem[i] = {~8'(i), 8'(i)};
      end
      model_mem[i] = mem[i];
    end
  endtask

  task automatic run_model();
    word_t      regs [8];
    word_t      w;
    word_t      a;
    word_t      b;
    word_t      diff;
    word_t      ea_sum;
    logic [2:0] rn;
    logic [2:0] rd;
    logic [2:0] rm;
    addr_t      pc;
    addr_t      ea;
    logic       running;
    int         i;
    for (i = 0; i < 8; i++) begin
      regs[i] = '0;
    end
    exp_flags = '0;
    pc        = 8'(`CPU_RESET_PC);
    running   = 1'b1;
    while (running && exp_addr.size() < 1000) begin
      w      = model_mem[pc];
      rn     = w[10:8];
      rd     = w[7:5];
      rm     = w[2:0];
      a      = regs[rn];
      b      = regs[rm];
      ea_sum = a + {{11{w[4]}}, w[4:0]};
      ea     = ea_sum[7:0];
      add_access(1'b0, pc, w);
      case (w[15:11])
        5'b11010: regs[rn] = {{8{w[7]}}, w[7:0]};
        5'b11000: regs[rd] = b;
        5'b10100: regs[rd] = a + b;
        5'b10101: begin
          diff        = a - b;
          exp_flags.z = (diff == '0);
          exp_flags.n = diff[15];
          exp_flags.v = (a[15] != b[15]) && (diff[15] != a[15]);
        end
        5'b10110: regs[rd] = a & b;
        5'b10111: regs[rd] = ~b;
        5'b01100: begin
          add_access(1'b0, ea, model_mem[ea]);
          regs[rd] = model_mem[ea];
        end
        5'b10000: begin
          add_access(1'b1, ea, regs[rd]);
          model_mem[ea] = regs[rd];
        end
        default: running = 1'b0;
      endcase
      if (running) begin
        pc = pc + 8'd1;
      end
    end
  endtask

  // Memory side of the four-phase bus
  task automatic serve_memory();
    int          cnt;
    int unsigned delay;
    logic        cur_we;
    addr_t       cur_addr;
    word_t       cur_wdata;
    string       tag;
    cnt = 0;
    while (rst_n) begin
      next_cycle();
      cnt++;
      if (cnt > 4 * RESET_CYCLES) fail_run("reset was never released");
    end
    while (!halted) begin
      cnt = 0;
      while (!mem_req && !halted) begin
        next_cycle();
        cnt++;
        if (cnt > REQ_TIMEOUT) fail_run("timeout waiting for a memory request");
      end
      if (mem_req) begin
        delay = $urandom % 6;
        repeat (delay) next_cycle();
        cur_we    = mem_we;
        cur_addr  = mem_addr;
        cur_wdata = mem_wdata;
        if (served >= exp_addr.size()) begin
          fail_run("memory request after the last expected access");
        end else begin
          tag = $sformatf("access %0d", served);
          check_bit({tag, " we"}, exp_we[served], cur_we);
          check_addr({tag, " address"}, exp_addr[served], cur_addr);
          if (cur_we) begin
            check_word({tag, " store data"}, exp_data[served], cur_wdata);
            mem[cur_addr] = cur_wdata;
          end else begin
            mem_rdata = mem[cur_addr];
          end
          served++;
        end
        mem_ack = 1'b1;
        cnt     = 0;
        while (mem_req) begin
          next_cycle();
          cnt++;
          if (cnt > ACK_TIMEOUT) fail_run("mem_req stayed high after mem_ack");
        end
        delay = $urandom % 6;
        repeat (delay) next_cycle();
        mem_ack = 1'b0;
      end
    end
  endtask

  initial begin : main
    int cnt;
    int i;
    rst_n     = 1'b1;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    served    = 0;
    void'($urandom(32'h76b5));
    build_program();
    load_memory();
    run_model();
    fork
      serve_memory();
    join_none
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b0;
    check_bit("mem_req after reset", 1'b0, mem_req);
    check_bit("halted after reset", 1'b0, halted);
    check_flags("flags after reset", '0, flags);
    cnt = 0;
    while (!halted) begin
      next_cycle();
      cnt++;
      if (cnt > HALT_TIMEOUT) fail_run("timeout waiting for halted");
    end
    if (served != exp_addr.size()) begin
      fail_run($sformatf("halted after %0d of %0d expected memory accesses",
                         served, exp_addr.size()));
    end
    check_flags("final flags", exp_flags, flags);
    // No bus activity once halted
    for (i = 0; i < QUIET_CYCLES; i++) begin
      next_cycle();
      if (mem_req) fail_run("memory request seen after halt");
      if (!halted) fail_run("halted dropped before reset");
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: all.f
+incdir+.
cpu_pkg.sv
dp_ctrl_if.sv
bus_ctrl_if.sv
bus_master.sv
control_fsm.sv
datapath.sv
cpu_top.sv
cpu_tb_assertions.sv
cpu_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = cpu_tb
FILELIST = all.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q -F "*** PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
